// File: alu_int_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_int_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    input  alu_pkg::exec_req_t    in_data,
    output logic                  in_ready,
    output logic                  out_valid,
    output alu_pkg::commit_t      out_data,
    input  logic                  out_ready,
    output logic                  branch_valid,
    output alu_pkg::branch_ctl_t  branch_data
);

    import alu_pkg::*;

    word_t [num_lanes-1:0]  lane_res;
    logic                   is_branch;
    logic                   br_taken;
    word_t                  br_target;
    logic                   in_fire;

    // Single output register, refilled while it drains
    assign in_ready = !out_valid || out_ready;
    assign in_fire  = in_valid && in_ready;

    assign is_branch = in_data.op inside {op_beq, op_bne, op_blt};

    // Per-lane ALU
    always_comb begin
        logic [4:0] shamt;
        for (int i = 0; i < num_lanes; i++) begin
            shamt = in_data.rs2[i][4:0];
            case (in_data.op)
                op_add:  lane_res[i] = in_data.rs1[i] + in_data.rs2[i];
                op_sub:  lane_res[i] = in_data.rs1[i] - in_data.rs2[i];
                op_and:  lane_res[i] = in_data.rs1[i] & in_data.rs2[i];
                op_or:   lane_res[i] = in_data.rs1[i] | in_data.rs2[i];
                op_xor:  lane_res[i] = in_data.rs1[i] ^ in_data.rs2[i];
                op_sll:  lane_res[i] = in_data.rs1[i] << shamt;
                op_srl:  lane_res[i] = in_data.rs1[i] >> shamt;
                op_sra:  lane_res[i] = word_t'($signed(in_data.rs1[i]) >>> shamt);
                op_slt:  lane_res[i] = word_t'($signed(in_data.rs1[i]) < $signed(in_data.rs2[i]));
                op_sltu: lane_res[i] = word_t'(in_data.rs1[i] < in_data.rs2[i]);
                default: lane_res[i] = '0;
            endcase
        end
    end

    // Branch outcome taken from the lowest active lane
    always_comb begin
        br_taken = 1'b0;
        for (int i = num_lanes - 1; i >= 0; i--) begin
            if (in_data.tmask[i] || i == 0 && in_data.tmask == '0) begin
                case (in_data.op)
                    op_beq:  br_taken = (in_data.rs1[i] == in_data.rs2[i]);
                    op_bne:  br_taken = (in_data.rs1[i] != in_data.rs2[i]);
                    op_blt:  br_taken = ($signed(in_data.rs1[i]) < $signed(in_data.rs2[i]));
                    default: br_taken = 1'b0;
                endcase
            end
        end
        br_target = br_taken ? in_data.pc + in_data.offset : in_data.pc + word_t'(4);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid    <= 1'b0;
            branch_valid <= 1'b0;
        end else begin
            if (in_ready) begin
                out_valid <= in_valid;
            end
            branch_valid <= in_fire && is_branch;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            out_data.uuid  <= in_data.uuid;
            out_data.wid   <= in_data.wid;
            out_data.tmask <= in_data.tmask;
            out_data.pc    <= in_data.pc;
            out_data.rd    <= in_data.rd;
            // Branches write nothing back
            out_data.wb    <= in_data.wb && !is_branch;
            out_data.data  <= is_branch ? '0 : lane_res;
        end
        if (in_fire && is_branch) begin
            branch_data.wid    <= in_data.wid;
            branch_data.taken  <= br_taken;
            branch_data.target <= br_target;
        end
    end

    a_no_branch_in_reset: assert property (
        @(posedge clk) reset |=> !branch_valid
    ) else $error("branch report raised during reset");

endmodule

`default_nettype wire

// File: alu_issue_ctl.sv
`timescale 1ns/1ps
`default_nettype none

module alu_issue_ctl (
    input  logic              clk,
    input  logic              reset,
    input  logic              disp_valid,
    input  alu_pkg::alu_op_t  disp_op,
    output logic              disp_ready,
    output logic              int_valid,
    input  logic              int_ready,
    output logic              mul_valid,
    input  logic              mul_ready
);

    import alu_pkg::*;

    logic sel_mul;

    // Opcode class picks the functional unit
    assign sel_mul = is_mul_op(disp_op);

    assign int_valid = disp_valid && !sel_mul;
    assign mul_valid = disp_valid && sel_mul;

    // Ready comes back only from the unit the request is steered to
    assign disp_ready = sel_mul ? mul_ready : int_ready;

    // Only one unit may see a request at a time
    a_one_unit: assert property (
        @(posedge clk) disable iff (reset)
        !(int_valid && mul_valid)
    ) else $error("int and mul units both selected");

    // A stalled request keeps its opcode, so it stays routed to the same unit
    a_stall_stable: assert property (
        @(posedge clk) disable iff (reset)
        disp_valid && !disp_ready |=> disp_valid && $stable(disp_op)
    ) else $error("dispatch request changed while stalled");

endmodule

`default_nettype wire

// File: alu_mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_mul_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  alu_pkg::exec_req_t  in_data,
    output logic                in_ready,
    output logic                out_valid,
    output alu_pkg::commit_t    out_data,
    input  logic                out_ready
);

    import alu_pkg::*;

    // Instruction fields that ride along the pipe
    typedef struct packed {
        uuid_t     uuid;
        wid_t      wid;
        tmask_t    tmask;
        word_t     pc;
        reg_idx_t  rd;
        logic      wb;
        alu_op_t   op;
    } mul_hdr_t;

    logic                          s1_valid;
    logic                          s2_valid;
    mul_hdr_t                      s1_hdr;
    mul_hdr_t                      s2_hdr;
    logic [num_lanes-1:0][xlen:0]  s1_a;
    logic [num_lanes-1:0][xlen:0]  s1_b;
    logic [num_lanes-1:0][63:0]    s2_prod;
    logic                          adv1;
    logic                          adv2;
    logic                          adv3;
    logic                          sext;

    // Each stage moves when the one after it is empty or moving
    assign adv3     = !out_valid || out_ready;
    assign adv2     = !s2_valid || adv3;
    assign adv1     = !s1_valid || adv2;
    assign in_ready = adv1;

    // Only mulh treats both operands as signed
    assign sext = (in_data.op == op_mulh);

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (adv1) s1_valid  <= in_valid;
            if (adv2) s2_valid  <= s1_valid;
            if (adv3) out_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        logic signed [2*xlen+1:0] prod;
        if (adv1 && in_valid) begin
            s1_hdr <= '{in_data.uuid, in_data.wid, in_data.tmask, in_data.pc,
                        in_data.rd, in_data.wb, in_data.op};
            for (int i = 0; i < num_lanes; i++) begin
                s1_a[i] <= {sext && in_data.rs1[i][xlen-1], in_data.rs1[i]};
                s1_b[i] <= {sext && in_data.rs2[i][xlen-1], in_data.rs2[i]};
            end
        end
        // Full 64-bit product per lane
        if (adv2 && s1_valid) begin
            s2_hdr <= s1_hdr;
            for (int i = 0; i < num_lanes; i++) begin
                prod = $signed(s1_a[i]) * $signed(s1_b[i]);
                s2_prod[i] <= prod[63:0];
            end
        end
        // Pick the low or high word
        if (adv3 && s2_valid) begin
            out_data.uuid  <= s2_hdr.uuid;
            out_data.wid   <= s2_hdr.wid;
            out_data.tmask <= s2_hdr.tmask;
            out_data.pc    <= s2_hdr.pc;
            out_data.rd    <= s2_hdr.rd;
            out_data.wb    <= s2_hdr.wb;
            for (int i = 0; i < num_lanes; i++) begin
                out_data.data[i] <= (s2_hdr.op == op_mul) ? s2_prod[i][31:0] : s2_prod[i][63:32];
            end
        end
    end

endmodule

`default_nettype wire

// File: alu_pkg.sv
`default_nettype none

package alu_pkg;

    // Core dimensions
    localparam int num_lanes = 4;
    localparam int xlen      = 32;
    localparam int num_warps = 8;
    localparam int nr_bits   = 5;
    localparam int uuid_bits = 8;

    typedef logic [xlen-1:0]               word_t;
    typedef logic [$clog2(num_warps)-1:0]  wid_t;
    typedef logic [nr_bits-1:0]            reg_idx_t;
    typedef logic [uuid_bits-1:0]          uuid_t;
    typedef logic [num_lanes-1:0]          tmask_t;

    // Integer, branch and multiply operations share one 4-bit opcode space
    typedef enum logic [3:0] {
        op_add, op_sub, op_and, op_or, op_xor,
        op_sll, op_srl, op_sra, op_slt, op_sltu,
        op_beq, op_bne, op_blt,
        op_mul, op_mulh, op_mulhu
    } alu_op_t;

    // Multiplies go to the pipelined unit, everything else to the integer unit
    function automatic logic is_mul_op(alu_op_t op);
        return op inside {op_mul, op_mulh, op_mulhu};
    endfunction

    // Instruction as issued by the dispatch stage
    typedef struct packed {
        uuid_t                  uuid;
        wid_t                   wid;
        tmask_t                 tmask;
        word_t                  pc;
        reg_idx_t               rd;
        logic                   wb;
        alu_op_t                op;
        word_t [num_lanes-1:0]  rs1;
        word_t [num_lanes-1:0]  rs2;
        word_t                  offset;
    } exec_req_t;

    // Writeback record toward the commit stage
    typedef struct packed {
        uuid_t                  uuid;
        wid_t                   wid;
        tmask_t                 tmask;
        word_t                  pc;
        reg_idx_t               rd;
        logic                   wb;
        word_t [num_lanes-1:0]  data;
    } commit_t;

    // Resolved branch sent back to the warp scheduler
    typedef struct packed {
        wid_t   wid;
        logic   taken;
        word_t  target;
    } branch_ctl_t;

endpackage

`default_nettype wire

// File: alu_rsp_arb.sv
`timescale 1ns/1ps
`default_nettype none

module alu_rsp_arb (
    input  logic              clk,
    input  logic              reset,
    input  logic              int_valid,
    input  alu_pkg::commit_t  int_data,
    output logic              int_ready,
    input  logic              mul_valid,
    input  alu_pkg::commit_t  mul_data,
    output logic              mul_ready,
    output logic              commit_valid,
    output alu_pkg::commit_t  commit_data,
    input  logic              commit_ready
);

    import alu_pkg::*;

    logic  prio_mul;
    logic  pick_mul;
    logic  load_en;
    logic  int_fire;
    logic  mul_fire;

    // Output register takes a new entry when empty or draining
    assign load_en = !commit_valid || commit_ready;

    // Round-robin only matters when both units are waiting
    assign pick_mul = (int_valid && mul_valid) ? prio_mul : mul_valid;

    assign int_ready = load_en && !pick_mul;
    assign mul_ready = load_en && pick_mul;

    assign int_fire = int_valid && int_ready;
    assign mul_fire = mul_valid && mul_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            prio_mul     <= 1'b0;
            commit_valid <= 1'b0;
        end else begin
            if (load_en) begin
                commit_valid <= int_valid || mul_valid;
            end
            // Hand priority to the other unit after a transfer
            if (mul_fire) begin
                prio_mul <= 1'b0;
            end else if (int_fire) begin
                prio_mul <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (int_fire || mul_fire) begin
            commit_data <= pick_mul ? mul_data : int_data;
        end
    end

    a_commit_hold: assert property (
        @(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit_data)
    ) else $error("commit output changed while stalled");

endmodule

`default_nettype wire

// File: alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  disp_valid,
    input  alu_pkg::exec_req_t    disp_data,
    output logic                  disp_ready,
    output logic                  commit_valid,
    output alu_pkg::commit_t      commit_data,
    input  logic                  commit_ready,
    output logic                  branch_valid,
    output alu_pkg::branch_ctl_t  branch_data
);

    import alu_pkg::*;

    // Dispatch side of each unit
    logic     int_valid;
    logic     int_ready;
    logic     mul_valid;
    logic     mul_ready;

    // Commit side of each unit
    logic     int_out_valid;
    logic     int_out_ready;
    commit_t  int_out_data;
    logic     mul_out_valid;
    logic     mul_out_ready;
    commit_t  mul_out_data;

    alu_issue_ctl i_issue_ctl (
        .clk        (clk),
        .reset      (reset),
        .disp_valid (disp_valid),
        .disp_op    (disp_data.op),
        .disp_ready (disp_ready),
        .int_valid  (int_valid),
        .int_ready  (int_ready),
        .mul_valid  (mul_valid),
        .mul_ready  (mul_ready)
    );

    alu_int_unit i_int_unit (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (int_valid),
        .in_data      (disp_data),
        .in_ready     (int_ready),
        .out_valid    (int_out_valid),
        .out_data     (int_out_data),
        .out_ready    (int_out_ready),
        .branch_valid (branch_valid),
        .branch_data  (branch_data)
    );

    alu_mul_unit i_mul_unit (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (mul_valid),
        .in_data   (disp_data),
        .in_ready  (mul_ready),
        .out_valid (mul_out_valid),
        .out_data  (mul_out_data),
        .out_ready (mul_out_ready)
    );

    alu_rsp_arb i_rsp_arb (
        .clk          (clk),
        .reset        (reset),
        .int_valid    (int_out_valid),
        .int_data     (int_out_data),
        .int_ready    (int_out_ready),
        .mul_valid    (mul_out_valid),
        .mul_data     (mul_out_data),
        .mul_ready    (mul_out_ready),
        .commit_valid (commit_valid),
        .commit_data  (commit_data),
        .commit_ready (commit_ready)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the ALU issue block testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_alu_unit -f sources.f -o sim_alu_unit
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/sim_alu_unit > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "SOME TESTS FAILED" "$log"; then
    echo "simulation reported failures, see $log"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status, see $log"
    exit 1
fi

echo "simulation finished cleanly"
exit 0

// File: sources.f
alu_pkg.sv
alu_issue_ctl.sv
alu_int_unit.sv
alu_mul_unit.sv
alu_rsp_arb.sv
alu_unit.sv
tb_alu_unit.sv

// File: tb_alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_alu_unit;

    import alu_pkg::*;

    localparam int reset_cycles    = 8;
    localparam int idle_cycles     = 10;
    localparam int num_lone        = 16;
    localparam int num_random      = 200;
    localparam int watchdog_cycles =
        reset_cycles + idle_cycles + 4 + 20 * (num_lone + num_random);

    logic         clk          = 1'b0;
    logic         reset        = 1'b1;
    logic         disp_valid   = 1'b0;
    exec_req_t    disp_data    = '0;
    logic         disp_ready;
    logic         commit_valid;
    commit_t      commit_data;
    logic         commit_ready = 1'b1;
    logic         branch_valid;
    branch_ctl_t  branch_data;

    // Reference results, indexed by uuid
    commit_t      exp_commit   [256];
    branch_ctl_t  exp_branch   [256];
    bit           exp_is_br    [256];
    int           exp_lat      [256];
    int           accept_cycle [256];
    bit           pending      [256];

    int           cycle;
    int           n_issued;
    int           n_accepted;
    int           n_committed;
    bit           fire_q;
    bit           br_due;
    branch_ctl_t  br_exp_q;
    bit           lone_mode;
    bit           ready_random;
    logic [31:0]  stim_seed  = 32'h3842;
    logic [31:0]  ready_seed = 32'h3842;

    bit           commit_known;
    commit_t      commit_exp;
    int           commit_lat;
    int           commit_lat_exp;

    alu_unit i_dut (
        .clk          (clk),
        .reset        (reset),
        .disp_valid   (disp_valid),
        .disp_data    (disp_data),
        .disp_ready   (disp_ready),
        .commit_valid (commit_valid),
        .commit_data  (commit_data),
        .commit_ready (commit_ready),
        .branch_valid (branch_valid),
        .branch_data  (branch_data)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic is_branch_op(input alu_op_t op);
        return op == op_beq || op == op_bne || op == op_blt;
    endfunction

    // Lane result straight from the opcode definitions
    function automatic word_t lane_result(input alu_op_t op, input word_t a, input word_t b);
        logic [63:0]         sra_ext;
        logic signed [63:0]  sa;
        logic signed [63:0]  sb;
        logic signed [63:0]  sprod;
        logic [63:0]         uprod;
        logic [4:0]          sh;
        sh      = b[4:0];
        sra_ext = {{32{a[31]}}, a} >> sh;
        sa      = {{32{a[31]}}, a};
        sb      = {{32{b[31]}}, b};
        sprod   = sa * sb;
        uprod   = {32'd0, a} * {32'd0, b};
        case (op)
            op_add:   return a + b;
            op_sub:   return a - b;
            op_and:   return a & b;
            op_or:    return a | b;
            op_xor:   return a ^ b;
            op_sll:   return a << sh;
            op_srl:   return a >> sh;
            op_sra:   return sra_ext[31:0];
            op_slt:   return (sa < sb) ? 32'd1 : 32'd0;
            op_sltu:  return (a < b) ? 32'd1 : 32'd0;
            op_mul:   return uprod[31:0];
            op_mulh:  return sprod[63:32];
            op_mulhu: return uprod[63:32];
            // Branches write zero
            default:  return 32'd0;
        endcase
    endfunction

    // Outcome decided by the first active lane counting up from lane 0
    function automatic branch_ctl_t branch_outcome(input exec_req_t r);
        branch_ctl_t  b;
        int           lane;
        bit           found;
        word_t        a;
        word_t        c;
        lane  = 0;
        found = 1'b0;
        for (int i = 0; i < num_lanes; i++) begin
            if (!found && r.tmask[i]) begin
                lane  = i;
                found = 1'b1;
            end
        end
        a     = r.rs1[lane];
        c     = r.rs2[lane];
        b.wid = r.wid;
        case (r.op)
            op_beq:  b.taken = (a == c);
            op_bne:  b.taken = (a != c);
            op_blt:  b.taken = ($signed(a) < $signed(c));
            default: b.taken = 1'b0;
        endcase
        b.target = b.taken ? r.pc + r.offset : r.pc + 32'd4;
        return b;
    endfunction

    function automatic commit_t expected_commit(input exec_req_t r);
        commit_t c;
        c.uuid  = r.uuid;
        c.wid   = r.wid;
        c.tmask = r.tmask;
        c.pc    = r.pc;
        c.rd    = r.rd;
        c.wb    = r.wb && !is_branch_op(r.op);
        for (int i = 0; i < num_lanes; i++) begin
            c.data[i] = lane_result(r.op, r.rs1[i], r.rs2[i]);
        end
        return c;
    endfunction

    task automatic fail_check(input string what);
        $display("error at %0t ns: %s", $time, what);
        $display("SOME TESTS FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic draw(output logic [31:0] w);
        stim_seed = lcg_next(stim_seed);
        w = stim_seed;
    endtask

    task automatic make_req(input alu_op_t op, output exec_req_t r);
        logic [31:0] w;
        r = '0;
        r.uuid = uuid_t'(n_issued);
        r.op   = op;
        draw(w);
        r.wid   = w[2:0];
        r.rd    = w[9:5];
        r.wb    = w[11];
        r.tmask = (w[15:12] == 4'd0) ? 4'b1000 : w[15:12];
        draw(w);
        r.pc = {w[31:2], 2'b00};
        draw(w);
        r.offset = {{19{w[12]}}, w[12:1], 1'b0};
        for (int i = 0; i < num_lanes; i++) begin
            draw(w);
            r.rs1[i] = w;
            draw(w);
            r.rs2[i] = w;
            // Equal operands now and then so compares go both ways
            if (w[3:2] == 2'b00) begin
                r.rs2[i] = r.rs1[i];
            end
        end
    endtask

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic send_req(input exec_req_t r);
        exp_commit[r.uuid] = expected_commit(r);
        exp_branch[r.uuid] = branch_outcome(r);
        exp_is_br[r.uuid]  = is_branch_op(r.op);
        exp_lat[r.uuid]    = is_mul_op(r.op) ? 4 : 2;
        disp_data  = r;
        disp_valid = 1'b1;
        @(negedge clk);
        while (!fire_q) begin
            @(negedge clk);
        end
        disp_valid = 1'b0;
        n_issued++;
    endtask

    task automatic wait_drain();
        while (n_committed != n_issued) begin
            @(negedge clk);
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (reset) begin
            fire_q <= 1'b0;
            br_due <= 1'b0;
        end else begin
            fire_q <= disp_valid && disp_ready;
            br_due <= disp_valid && disp_ready && exp_is_br[disp_data.uuid];
            if (disp_valid && disp_ready) begin
                pending[disp_data.uuid]      <= 1'b1;
                accept_cycle[disp_data.uuid] <= cycle;
                br_exp_q                     <= exp_branch[disp_data.uuid];
                n_accepted                   <= n_accepted + 1;
            end
            if (commit_valid && commit_ready) begin
                pending[commit_data.uuid] <= 1'b0;
                n_committed               <= n_committed + 1;
            end
        end
    end

    // Back-pressure source, about one stalled cycle in four
    always @(negedge clk) begin
        if (ready_random) begin
            ready_seed = lcg_next(ready_seed);
            commit_ready <= (ready_seed[30:29] != 2'b00);
        end else begin
            commit_ready <= 1'b1;
        end
    end

    always_comb begin
        commit_known   = pending[commit_data.uuid];
        commit_exp     = exp_commit[commit_data.uuid];
        commit_lat     = cycle - accept_cycle[commit_data.uuid];
        commit_lat_exp = exp_lat[commit_data.uuid];
    end

    a_quiet_after_reset: assert property (
        @(posedge clk) disable iff (reset)
        n_accepted == 0 |-> !commit_valid && !branch_valid
    ) else fail_check("output valid raised before any request was accepted");

    a_commit_known: assert property (
        @(posedge clk) disable iff (reset)
        commit_valid |-> commit_known
    ) else fail_check($sformatf("uuid %0d committed but not outstanding", commit_data.uuid));

    a_commit_data: assert property (
        @(posedge clk) disable iff (reset)
        commit_valid |-> commit_data == commit_exp
    ) else fail_check($sformatf("uuid %0d commit %h, expected %h",
                                commit_data.uuid, commit_data, commit_exp));

    a_commit_hold: assert property (
        @(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit_data)
    ) else fail_check("commit output changed while stalled");

    a_lone_latency: assert property (
        @(posedge clk) disable iff (reset)
        lone_mode && commit_valid |-> commit_lat == commit_lat_exp
    ) else fail_check($sformatf("uuid %0d latency %0d, expected %0d",
                                commit_data.uuid, commit_lat, commit_lat_exp));

    a_branch_pulse: assert property (
        @(posedge clk) disable iff (reset)
        branch_valid == br_due
    ) else fail_check($sformatf("branch_valid %0b, expected %0b", branch_valid, br_due));

    a_branch_data: assert property (
        @(posedge clk) disable iff (reset)
        branch_valid |-> branch_data == br_exp_q
    ) else fail_check($sformatf("branch report %h, expected %h", branch_data, br_exp_q));

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, %0d of %0d instructions committed",
                 watchdog_cycles, n_committed, n_issued);
        $display("SOME TESTS FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        exec_req_t    r;
        logic [31:0]  w;
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;

        // Idle under random back-pressure, nothing may come out
        ready_random <= 1'b1;
        repeat (idle_cycles) @(negedge clk);
        ready_random <= 1'b0;
        repeat (2) @(negedge clk);

        // Every opcode alone with commit_ready high
        lone_mode = 1'b1;
        for (int k = 0; k < num_lone; k++) begin
            make_req(alu_op_t'(4'(k)), r);
            send_req(r);
            wait_drain();
        end
        @(negedge clk);
        lone_mode = 1'b0;

        // Random mix with commit_ready toggling
        ready_random <= 1'b1;
        for (int k = 0; k < num_random; k++) begin
            draw(w);
            make_req(alu_op_t'(w[27:24]), r);
            send_req(r);
            if (w[31:30] == 2'b00) begin
                repeat (2) @(negedge clk);
            end
        end
        ready_random <= 1'b0;
        wait_drain();
        repeat (4) @(negedge clk);

        if (n_committed == n_issued && n_accepted == n_issued) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("count mismatch: %0d issued, %0d accepted, %0d committed",
                     n_issued, n_accepted, n_committed);
            $display("SOME TESTS FAILED");
            $fatal(1, "count mismatch");
        end
    end

endmodule

`default_nettype wire
